// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // memory operations from the execute stage
  typedef enum logic [3:0] {
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_sb,
    op_sh,
    op_sw
  } lsu_op_e;

  // data and address width, byte lanes assume 32
  localparam int xlen = 32;

  // address map classes
  typedef enum logic [1:0] {
    region_none,
    region_cached,
    region_device
  } region_e;

  // cacheable memory window, limit exclusive
  localparam logic [31:0] mem_base  = 32'h8000_0000;
  localparam logic [31:0] mem_limit = 32'h8040_0000;

  // uncached device window, limit exclusive
  localparam logic [31:0] dev_base  = 32'h1000_0000;
  localparam logic [31:0] dev_limit = 32'h1002_0000;

  // axi response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== source/lsu_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_req_decode (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      req_valid,
  input  lsu_pkg::lsu_op_e          req_op,
  input  logic [lsu_pkg::xlen-1:0]  req_addr,
  input  logic [lsu_pkg::xlen-1:0]  req_wdata,
  input  logic                      cache_idle,
  output logic                      req_ready,
  output logic                      dec_valid,
  output logic                      dec_store,
  output lsu_pkg::region_e          dec_region,
  output logic [lsu_pkg::xlen-1:0]  dec_word_addr,
  output logic [3:0]                dec_strb,
  output logic [lsu_pkg::xlen-1:0]  dec_wdata,
  output logic                      dec_error
);

  lsu_pkg::region_e          region;
  logic                      store;
  logic                      misaligned;
  logic [3:0]                strb;
  logic [lsu_pkg::xlen-1:0]  wdata_lane;
  logic                      accept;

  assign accept = req_valid && req_ready;
  // dec_valid doubles as the pending flag, the cache has not left idle yet
  assign req_ready = cache_idle && !dec_valid;

  always_comb begin
    if (req_addr >= lsu_pkg::mem_base && req_addr < lsu_pkg::mem_limit) begin
      region = lsu_pkg::region_cached;
    end else if (req_addr >= lsu_pkg::dev_base && req_addr < lsu_pkg::dev_limit) begin
      region = lsu_pkg::region_device;
    end else begin
      region = lsu_pkg::region_none;
    end
  end

  always_comb begin
    store      = 1'b0;
    misaligned = 1'b0;
    strb       = 4'b0000;
    wdata_lane = req_wdata;
    case (req_op)
      lsu_pkg::op_lb, lsu_pkg::op_lbu: begin
        misaligned = 1'b0;
      end
      lsu_pkg::op_lh, lsu_pkg::op_lhu: begin
        misaligned = req_addr[0];
      end
      lsu_pkg::op_lw: begin
        misaligned = |req_addr[1:0];
      end
      lsu_pkg::op_sb: begin
        store      = 1'b1;
        strb       = 4'b0001 << req_addr[1:0];
        wdata_lane = {4{req_wdata[7:0]}};
      end
      lsu_pkg::op_sh: begin
        store      = 1'b1;
        misaligned = req_addr[0];
        strb       = 4'b0011 << req_addr[1:0];
        wdata_lane = {2{req_wdata[15:0]}};
      end
      lsu_pkg::op_sw: begin
        store      = 1'b1;
        misaligned = |req_addr[1:0];
        strb       = 4'b1111;
      end
      default: begin
        // undefined opcode is refused like a bad address
        misaligned = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  // held until the next acceptance, the cache reads them while waiting
  always_ff @(posedge clock) begin
    if (accept) begin
      dec_store     <= store;
      dec_region    <= region;
      dec_word_addr <= {req_addr[lsu_pkg::xlen-1:2], 2'b00};
      dec_strb      <= strb;
      dec_wdata     <= wdata_lane;
      dec_error     <= misaligned || (region == lsu_pkg::region_none);
    end
  end

endmodule

`default_nettype wire

// ==== source/l1d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_cache #(
  parameter int l1d_index_bits = 4
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dec_valid,
  input  logic                      dec_store,
  input  lsu_pkg::region_e          dec_region,
  input  logic [lsu_pkg::xlen-1:0]  dec_word_addr,
  input  logic [3:0]                dec_strb,
  input  logic [lsu_pkg::xlen-1:0]  dec_wdata,
  input  logic                      dec_error,
  input  logic                      rd_done,
  input  logic [lsu_pkg::xlen-1:0]  rd_data,
  input  logic                      rd_err,
  input  logic                      wr_done,
  input  logic                      wr_err,
  output logic                      cache_idle,
  output logic                      rd_start,
  output logic [lsu_pkg::xlen-1:0]  rd_addr,
  output logic                      wr_start,
  output logic [lsu_pkg::xlen-1:0]  wr_addr,
  output logic [lsu_pkg::xlen-1:0]  wr_data,
  output logic [3:0]                wr_strb,
  output logic                      fin_valid,
  output logic [lsu_pkg::xlen-1:0]  fin_word,
  output logic                      fin_error
);

  localparam int lines    = 1 << l1d_index_bits;
  localparam int tag_bits = lsu_pkg::xlen - l1d_index_bits - 2;

  typedef enum logic [1:0] {
    st_idle,
    st_read_wait,
    st_write_wait
  } state_e;

  state_e state;

  logic [lsu_pkg::xlen-1:0]  data_mem [lines];
  logic [tag_bits-1:0]       tag_mem [lines];
  logic [lines-1:0]          valid_q;

  logic [l1d_index_bits-1:0] idx;
  logic [tag_bits-1:0]       tag;
  logic                      hit;
  logic                      go;
  logic                      fill_q;
  logic                      fin_q;

  assign idx = dec_word_addr[l1d_index_bits+1:2];
  assign tag = dec_word_addr[lsu_pkg::xlen-1:l1d_index_bits+2];
  assign hit = valid_q[idx] && (tag_mem[idx] == tag) && (dec_region == lsu_pkg::region_cached);

  // a new request that passed decode
  assign go = (state == st_idle) && dec_valid && !dec_error;

  assign rd_start = go && !dec_store && !hit;
  assign wr_start = go && dec_store;
  assign rd_addr  = dec_word_addr;
  assign wr_addr  = dec_word_addr;
  assign wr_data  = dec_wdata;
  assign wr_strb  = dec_strb;

  always_comb begin
    fin_valid = 1'b0;
    fin_error = 1'b0;
    fin_word  = data_mem[idx];
    case (state)
      st_idle: begin
        fin_valid = dec_valid && (dec_error || (!dec_store && hit));
        fin_error = dec_error;
      end
      st_read_wait: begin
        fin_valid = rd_done;
        fin_error = rd_err;
        fin_word  = rd_data;
      end
      st_write_wait: begin
        fin_valid = wr_done;
        fin_error = wr_err;
      end
      default: begin
        fin_valid = 1'b0;
      end
    endcase
  end

  // also busy while the aligner presents the response
  assign cache_idle = (state == st_idle) && !fin_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= st_idle;
      valid_q <= '0;
      fill_q  <= 1'b0;
      fin_q   <= 1'b0;
    end else begin
      fin_q <= fin_valid;
      case (state)
        st_idle: begin
          if (rd_start) begin
            state  <= st_read_wait;
            fill_q <= (dec_region == lsu_pkg::region_cached);
          end else if (wr_start) begin
            state <= st_write_wait;
            // write-through, no allocate
            if (hit) begin
              valid_q[idx] <= 1'b0;
            end
          end
        end
        st_read_wait: begin
          if (rd_done) begin
            state <= st_idle;
            if (fill_q && !rd_err) begin
              valid_q[idx] <= 1'b1;
            end
          end
        end
        st_write_wait: begin
          if (wr_done) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_read_wait && rd_done && fill_q && !rd_err) begin
      data_mem[idx] <= rd_data;
      tag_mem[idx]  <= tag;
    end
  end

endmodule

`default_nettype wire

// ==== source/axil_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_master (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      rd_start,
  input  logic [lsu_pkg::xlen-1:0]  rd_addr,
  input  logic                      wr_start,
  input  logic [lsu_pkg::xlen-1:0]  wr_addr,
  input  logic [lsu_pkg::xlen-1:0]  wr_data,
  input  logic [3:0]                wr_strb,
  input  logic                      arready,
  input  logic [lsu_pkg::xlen-1:0]  rdata,
  input  logic [1:0]                rresp,
  input  logic                      rvalid,
  input  logic                      awready,
  input  logic                      wready,
  input  logic [1:0]                bresp,
  input  logic                      bvalid,
  output logic                      rd_done,
  output logic [lsu_pkg::xlen-1:0]  rd_data,
  output logic                      rd_err,
  output logic                      wr_done,
  output logic                      wr_err,
  output logic [lsu_pkg::xlen-1:0]  araddr,
  output logic                      arvalid,
  output logic                      rready,
  output logic [lsu_pkg::xlen-1:0]  awaddr,
  output logic                      awvalid,
  output logic [lsu_pkg::xlen-1:0]  wdata,
  output logic [3:0]                wstrb,
  output logic                      wvalid,
  output logic                      bready
);

  typedef enum logic [1:0] {
    m_idle,
    m_read,
    m_write
  } mstate_e;

  mstate_e state;
  logic    rd_go;
  logic    wr_go;

  assign rd_go = (state == m_idle) && rd_start;
  assign wr_go = (state == m_idle) && wr_start && !rd_start;

  // response channels open once the address side is done
  assign rready = (state == m_read) && !arvalid;
  assign bready = (state == m_write) && !awvalid && !wvalid;

  assign rd_done = rready && rvalid;
  assign rd_data = rdata;
  assign rd_err  = (rresp == lsu_pkg::resp_slverr);
  assign wr_done = bready && bvalid;
  assign wr_err  = (bresp == lsu_pkg::resp_slverr);

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= m_idle;
      arvalid <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      case (state)
        m_idle: begin
          if (rd_go) begin
            state   <= m_read;
            arvalid <= 1'b1;
          end else if (wr_go) begin
            state   <= m_write;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
          end
        end
        m_read: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
          end
          if (rd_done) begin
            state <= m_idle;
          end
        end
        m_write: begin
          // aw and w may be taken in either order
          if (awvalid && awready) begin
            awvalid <= 1'b0;
          end
          if (wvalid && wready) begin
            wvalid <= 1'b0;
          end
          if (wr_done) begin
            state <= m_idle;
          end
        end
        default: begin
          state <= m_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (rd_go) begin
      araddr <= rd_addr;
    end
    if (wr_go) begin
      awaddr <= wr_addr;
      wdata  <= wr_data;
      wstrb  <= wr_strb;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      req_valid,
  input  logic                      req_ready,
  input  lsu_pkg::lsu_op_e          req_op,
  input  logic [lsu_pkg::xlen-1:0]  req_addr,
  input  logic                      fin_valid,
  input  logic [lsu_pkg::xlen-1:0]  fin_word,
  input  logic                      fin_error,
  output logic                      resp_valid,
  output logic [lsu_pkg::xlen-1:0]  resp_rdata,
  output logic                      resp_error
);

  lsu_pkg::lsu_op_e          op_q;
  logic [1:0]                off_q;
  logic [lsu_pkg::xlen-1:0]  shifted;
  logic [lsu_pkg::xlen-1:0]  load_data;

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      op_q  <= req_op;
      off_q <= req_addr[1:0];
    end
  end

  assign shifted = fin_word >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      lsu_pkg::op_lb:  load_data = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::op_lbu: load_data = {24'h000000, shifted[7:0]};
      lsu_pkg::op_lh:  load_data = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::op_lhu: load_data = {16'h0000, shifted[15:0]};
      lsu_pkg::op_lw:  load_data = shifted;
      // stores return no data
      default:         load_data = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= fin_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (fin_valid) begin
      resp_error <= fin_error;
      resp_rdata <= fin_error ? '0 : load_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int l1d_index_bits = 4
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  lsu_pkg::lsu_op_e          req_op,
  input  logic [lsu_pkg::xlen-1:0]  req_addr,
  input  logic [lsu_pkg::xlen-1:0]  req_wdata,
  output logic                      resp_valid,
  output logic [lsu_pkg::xlen-1:0]  resp_rdata,
  output logic                      resp_error,
  output logic [lsu_pkg::xlen-1:0]  awaddr,
  output logic                      awvalid,
  input  logic                      awready,
  output logic [lsu_pkg::xlen-1:0]  wdata,
  output logic [3:0]                wstrb,
  output logic                      wvalid,
  input  logic                      wready,
  input  logic [1:0]                bresp,
  input  logic                      bvalid,
  output logic                      bready,
  output logic [lsu_pkg::xlen-1:0]  araddr,
  output logic                      arvalid,
  input  logic                      arready,
  input  logic [lsu_pkg::xlen-1:0]  rdata,
  input  logic [1:0]                rresp,
  input  logic                      rvalid,
  output logic                      rready
);

  logic                      cache_idle;
  logic                      dec_valid;
  logic                      dec_store;
  lsu_pkg::region_e          dec_region;
  logic [lsu_pkg::xlen-1:0]  dec_word_addr;
  logic [3:0]                dec_strb;
  logic [lsu_pkg::xlen-1:0]  dec_wdata;
  logic                      dec_error;

  logic                      rd_start;
  logic [lsu_pkg::xlen-1:0]  rd_addr;
  logic                      rd_done;
  logic [lsu_pkg::xlen-1:0]  rd_data;
  logic                      rd_err;
  logic                      wr_start;
  logic [lsu_pkg::xlen-1:0]  wr_addr;
  logic [lsu_pkg::xlen-1:0]  wr_data;
  logic [3:0]                wr_strb;
  logic                      wr_done;
  logic                      wr_err;

  logic                      fin_valid;
  logic [lsu_pkg::xlen-1:0]  fin_word;
  logic                      fin_error;

  lsu_req_decode decode0 (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .cache_idle    (cache_idle),
    .req_ready     (req_ready),
    .dec_valid     (dec_valid),
    .dec_store     (dec_store),
    .dec_region    (dec_region),
    .dec_word_addr (dec_word_addr),
    .dec_strb      (dec_strb),
    .dec_wdata     (dec_wdata),
    .dec_error     (dec_error)
  );

  l1d_cache #(
    .l1d_index_bits (l1d_index_bits)
  ) cache0 (
    .clock         (clock),
    .reset         (reset),
    .dec_valid     (dec_valid),
    .dec_store     (dec_store),
    .dec_region    (dec_region),
    .dec_word_addr (dec_word_addr),
    .dec_strb      (dec_strb),
    .dec_wdata     (dec_wdata),
    .dec_error     (dec_error),
    .rd_done       (rd_done),
    .rd_data       (rd_data),
    .rd_err        (rd_err),
    .wr_done       (wr_done),
    .wr_err        (wr_err),
    .cache_idle    (cache_idle),
    .rd_start      (rd_start),
    .rd_addr       (rd_addr),
    .wr_start      (wr_start),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .fin_valid     (fin_valid),
    .fin_word      (fin_word),
    .fin_error     (fin_error)
  );

  axil_master master0 (
    .clock    (clock),
    .reset    (reset),
    .rd_start (rd_start),
    .rd_addr  (rd_addr),
    .wr_start (wr_start),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .awready  (awready),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .rd_done  (rd_done),
    .rd_data  (rd_data),
    .rd_err   (rd_err),
    .wr_done  (wr_done),
    .wr_err   (wr_err),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .rready   (rready),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .bready   (bready)
  );

  lsu_load_align align0 (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .fin_valid  (fin_valid),
    .fin_word   (fin_word),
    .fin_error  (fin_error),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_error (resp_error)
  );

endmodule

`default_nettype wire

// ==== verif/axil_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model #(
  parameter logic [31:0] seed     = 32'h5eaeab32,
  parameter logic [31:0] err_addr = 32'h8000_0f00
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  // 4 KiB of words, every window aliases on address bits 11:2
  logic [31:0] words [1024];
  logic [31:0] dly_state;
  logic        aw_seen;
  logic        w_seen;
  logic [31:0] aw_q;
  logic [31:0] w_q;
  logic [3:0]  strb_q;

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    logic [31:0] s;
    s = seed;
    for (int i = 0; i < 1024; i++) begin
      s = lcg_step(s);
      words[i[9:0]] = s;
    end
    arready = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    rvalid  = 1'b0;
    bvalid  = 1'b0;
    rdata   = '0;
    rresp   = lsu_pkg::resp_okay;
    bresp   = lsu_pkg::resp_okay;
  end

  always @(posedge clock) begin
    if (reset) begin
      dly_state <= seed;
      arready   <= 1'b0;
      awready   <= 1'b0;
      wready    <= 1'b0;
      rvalid    <= 1'b0;
      bvalid    <= 1'b0;
      aw_seen   <= 1'b0;
      w_seen    <= 1'b0;
    end else begin
      dly_state <= lcg_step(dly_state);
      // read channel, one beat at a time
      if (arvalid && arready) begin
        arready <= 1'b0;
        rvalid  <= 1'b1;
        rdata   <= words[araddr[11:2]];
        rresp   <= (araddr == err_addr) ? lsu_pkg::resp_slverr : lsu_pkg::resp_okay;
      end else begin
        arready <= dly_state[16] && !rvalid;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      // aw and w land in any order
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_seen <= 1'b1;
        aw_q    <= awaddr;
      end else begin
        awready <= dly_state[17] && !aw_seen && !bvalid;
      end
      if (wvalid && wready) begin
        wready <= 1'b0;
        w_seen <= 1'b1;
        w_q    <= wdata;
        strb_q <= wstrb;
      end else begin
        wready <= dly_state[18] && !w_seen && !bvalid;
      end
      if (aw_seen && w_seen && !bvalid) begin
        aw_seen <= 1'b0;
        w_seen  <= 1'b0;
        bvalid  <= 1'b1;
        bresp   <= (aw_q == err_addr) ? lsu_pkg::resp_slverr : lsu_pkg::resp_okay;
        if (aw_q != err_addr) begin
          for (int b = 0; b < 4; b++) begin
            if (strb_q[b]) begin
              words[aw_q[11:2]][8*b +: 8] <= w_q[8*b +: 8];
            end
          end
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  localparam logic [31:0] seed         = 32'h5eaeab32;
  localparam logic [31:0] err_addr     = 32'h8000_0f00;
  localparam int          reset_cycles = 8;
  localparam int          n_ext        = 32;
  localparam int          n_store      = 9;
  localparam int          n_requests   = 2 + n_ext + 3 * n_store + 2 + 5;

  logic              clock = 1'b0;
  logic              reset;
  logic              req_valid;
  logic              req_ready;
  lsu_pkg::lsu_op_e  req_op;
  logic [31:0]       req_addr;
  logic [31:0]       req_wdata;
  logic              resp_valid;
  logic [31:0]       resp_rdata;
  logic              resp_error;
  logic [31:0]       awaddr;
  logic              awvalid;
  logic              awready;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [31:0]       araddr;
  logic              arvalid;
  logic              arready;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  // byte image of the 4 KiB that mem0 holds
  logic [7:0]  ref_mem [4096];
  logic [31:0] rand_state;
  int          ar_count;
  int          aw_count;

  lsu_top #(.l1d_index_bits(4)) dut0 (.*);

  axil_mem_model #(.seed(seed), .err_addr(err_addr)) mem0 (.*);

  always #2 clock = ~clock;

  always @(posedge clock) begin
    if (reset) begin
      ar_count <= 0;
      aw_count <= 0;
    end else begin
      if (arvalid && arready) begin
        ar_count <= ar_count + 1;
      end
      if (awvalid && awready) begin
        aw_count <= aw_count + 1;
      end
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // valid holds its payload until ready
  ar_stable: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else stop_with_failure("arvalid or araddr changed before arready");
  aw_stable: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else stop_with_failure("awvalid or awaddr changed before awready");
  w_stable: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else stop_with_failure("wvalid or write data changed before wready");
  r_stable: assert property (@(posedge clock) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else stop_with_failure("rvalid or read data changed before rready");
  b_stable: assert property (@(posedge clock) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else stop_with_failure("bvalid or bresp changed before bready");

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    rand_state = lcg_next(rand_state);
    return rand_state;
  endfunction

  // same sequence that mem0 loads into its words
  task automatic preload_ref();
    logic [31:0] s;
    s = seed;
    for (int i = 0; i < 1024; i++) begin
      s = lcg_next(s);
      ref_mem[{i[9:0], 2'd0}] = s[7:0];
      ref_mem[{i[9:0], 2'd1}] = s[15:8];
      ref_mem[{i[9:0], 2'd2}] = s[23:16];
      ref_mem[{i[9:0], 2'd3}] = s[31:24];
    end
    rand_state = s;
  endtask

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [11:0] a;
    a = {addr[11:2], 2'b00};
    return {ref_mem[a + 12'd3], ref_mem[a + 12'd2], ref_mem[a + 12'd1], ref_mem[a]};
  endfunction

  // bytes at the addressed location, little endian, then extended
  function automatic logic [31:0] expected_load(input lsu_pkg::lsu_op_e op,
                                                input logic [31:0] addr);
    logic [11:0] a;
    logic [7:0]  lo;
    logic [7:0]  hi;
    a  = addr[11:0];
    lo = ref_mem[a];
    hi = ref_mem[a + 12'd1];
    case (op)
      lsu_pkg::op_lb:  return {{24{lo[7]}}, lo};
      lsu_pkg::op_lbu: return {24'h000000, lo};
      lsu_pkg::op_lh:  return {{16{hi[7]}}, hi, lo};
      lsu_pkg::op_lhu: return {16'h0000, hi, lo};
      lsu_pkg::op_lw:  return ref_word(addr);
      default:         return 32'h0;
    endcase
  endfunction

  task automatic store_to_ref(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                              input logic [31:0] data);
    logic [11:0] a;
    a = addr[11:0];
    case (op)
      lsu_pkg::op_sb: begin
        ref_mem[a] = data[7:0];
      end
      lsu_pkg::op_sh: begin
        ref_mem[a]          = data[7:0];
        ref_mem[a + 12'd1]  = data[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) begin
          ref_mem[a + i[11:0]] = data[8*i +: 8];
        end
      end
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else stop_with_failure($sformatf("FAILED %s expected %08h actual %08h",
                                       name, expected, actual));
  endtask

  task automatic check_quiet(input string name);
    check_value({name, " resp_valid"}, 32'd0, 32'(resp_valid));
    check_value({name, " arvalid"}, 32'd0, 32'(arvalid));
    check_value({name, " awvalid"}, 32'd0, 32'(awvalid));
    check_value({name, " wvalid"}, 32'd0, 32'(wvalid));
  endtask

  // latency counts cycles from the accepting cycle to resp_valid
  task automatic send_request(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                              input logic [31:0] data, output logic [31:0] load_data,
                              output logic error, output int latency);
    @(negedge clock);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = data;
    while (!req_ready) begin
      @(negedge clock);
    end
    @(negedge clock);
    req_valid = 1'b0;
    latency   = 1;
    while (!resp_valid) begin
      @(negedge clock);
      latency++;
    end
    load_data = resp_rdata;
    error     = resp_error;
  endtask

  task automatic check_refused(input string name, input lsu_pkg::lsu_op_e op,
                               input logic [31:0] addr);
    logic [31:0] load_data;
    logic        error;
    int          latency;
    int          reads;
    int          writes;
    reads  = ar_count;
    writes = aw_count;
    send_request(op, addr, 32'h0, load_data, error, latency);
    check_value({name, " error"}, 32'd1, 32'(error));
    check_value({name, " latency"}, 32'd2, 32'(latency));
    check_value({name, " reads"}, 32'd0, 32'(ar_count - reads));
    check_value({name, " writes"}, 32'd0, 32'(aw_count - writes));
  endtask

  initial begin
    repeat (n_requests * 200 + reset_cycles) @(posedge clock);
    stop_with_failure("timeout, the requests did not all complete in time");
  end

  initial begin
    logic [31:0]      load_data;
    logic [31:0]      store_data;
    logic [31:0]      addr;
    logic [31:0]      r;
    logic [1:0]       off;
    logic             error;
    int               latency;
    int               reads;
    lsu_pkg::lsu_op_e op;

    reset     = 1'b1;
    req_valid = 1'b0;
    req_op    = lsu_pkg::op_lw;
    req_addr  = 32'h0;
    req_wdata = 32'h0;
    preload_ref();

    repeat (reset_cycles) begin
      @(negedge clock);
      check_quiet("reset");
    end
    reset = 1'b0;
    @(negedge clock);
    check_quiet("after reset");
    check_value("after reset req_ready", 32'd1, 32'(req_ready));

    // miss then hit on the same word
    addr  = lsu_pkg::mem_base + 32'h100;
    reads = ar_count;
    send_request(lsu_pkg::op_lw, addr, 32'h0, load_data, error, latency);
    check_value("miss error", 32'd0, 32'(error));
    check_value("miss data", ref_word(addr), load_data);
    check_value("miss reads", 32'd1, 32'(ar_count - reads));
    reads = ar_count;
    send_request(lsu_pkg::op_lw, addr, 32'h0, load_data, error, latency);
    check_value("hit data", ref_word(addr), load_data);
    check_value("hit reads", 32'd0, 32'(ar_count - reads));
    check_value("hit latency", 32'd2, 32'(latency));

    // every opcode against every legal offset
    for (int i = 0; i < n_ext; i++) begin
      r   = next_random();
      off = 2'((i / 4) % 4);
      case (i % 4)
        0: op = lsu_pkg::op_lb;
        1: op = lsu_pkg::op_lbu;
        2: op = lsu_pkg::op_lh;
        default: op = lsu_pkg::op_lhu;
      endcase
      if (i % 4 >= 2) begin
        off[0] = 1'b0;
      end
      addr = lsu_pkg::mem_base + {21'd0, r[10:2], off};
      send_request(op, addr, 32'h0, load_data, error, latency);
      check_value($sformatf("extension %s error", op.name()), 32'd0, 32'(error));
      check_value($sformatf("extension %s at %08h", op.name(), addr),
                  expected_load(op, addr), load_data);
    end

    // store into a line that is cached, then read it back
    for (int i = 0; i < n_store; i++) begin
      r          = next_random();
      store_data = next_random();
      addr       = lsu_pkg::mem_base + {21'd0, r[10:2], 2'b00};
      send_request(lsu_pkg::op_lw, addr, 32'h0, load_data, error, latency);
      check_value("store warmup data", ref_word(addr), load_data);
      case (i % 3)
        0: begin
          op  = lsu_pkg::op_sb;
          off = r[12:11];
        end
        1: begin
          op  = lsu_pkg::op_sh;
          off = {r[11], 1'b0};
        end
        default: begin
          op  = lsu_pkg::op_sw;
          off = 2'b00;
        end
      endcase
      send_request(op, {addr[31:2], off}, store_data, load_data, error, latency);
      check_value($sformatf("store %s error", op.name()), 32'd0, 32'(error));
      store_to_ref(op, {addr[31:2], off}, store_data);
      reads = ar_count;
      send_request(lsu_pkg::op_lw, addr, 32'h0, load_data, error, latency);
      check_value("store reload reads", 32'd1, 32'(ar_count - reads));
      check_value($sformatf("store reload at %08h", addr), ref_word(addr), load_data);
      check_value($sformatf("store memory at %08h", addr), ref_word(addr),
                  mem0.words[addr[11:2]]);
    end

    // device loads never allocate
    addr = lsu_pkg::dev_base + 32'h840;
    for (int i = 0; i < 2; i++) begin
      reads = ar_count;
      send_request(lsu_pkg::op_lw, addr, 32'h0, load_data, error, latency);
      check_value("device error", 32'd0, 32'(error));
      check_value("device reads", 32'd1, 32'(ar_count - reads));
      check_value("device data", ref_word(addr), load_data);
    end

    check_refused("outside map", lsu_pkg::op_lw, 32'h2000_0000);
    check_refused("misaligned lh", lsu_pkg::op_lh, lsu_pkg::mem_base + 32'h101);
    check_refused("misaligned sw", lsu_pkg::op_sw, lsu_pkg::mem_base + 32'h102);

    // slave error must not fill the line
    for (int i = 0; i < 2; i++) begin
      reads = ar_count;
      send_request(lsu_pkg::op_lw, err_addr, 32'h0, load_data, error, latency);
      check_value("slave error flag", 32'd1, 32'(error));
      check_value("slave error reads", 32'd1, 32'(ar_count - reads));
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
source/lsu_pkg.sv
source/lsu_req_decode.sv
source/l1d_cache.sv
source/axil_master.sv
source/lsu_load_align.sv
source/lsu_top.sv
verif/axil_mem_model.sv
verif/tb_lsu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_lsu
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJDIR)
